/* verilog/routerPkg.sv */
package routerPkg;

  localparam int numPorts = 5;
  localparam int lengthW = 12; // length field and timer count.
  localparam int dataW = 16;

  // input directions in rotation order
  typedef enum logic [2:0]
  {
    pL = 3'd0,
    pN = 3'd1,
    pE = 3'd2,
    pW = 3'd3,
    pS = 3'd4
  } portE;

  typedef enum logic [2:0]
  {
    kIdle = 3'd0,
    kHead = 3'd1, // carries a valid length.
    kBody = 3'd2,
    kTail = 3'd3
  } flitKindE;

  // bit 0 is idle, bit p+1 means port p owns the output
  typedef enum logic [5:0]
  {
    sIdle = 6'b000001,
    sOwnL = 6'b000010,
    sOwnN = 6'b000100,
    sOwnE = 6'b001000,
    sOwnW = 6'b010000,
    sOwnS = 6'b100000
  } arbStateE;

endpackage

/* verilog/flitPortIf.sv */
`timescale 1ns/1ps

interface flitPortIf
  import routerPkg::*;
();

  logic req; // buffer not empty.
  flitKindE flitId;
  logic [lengthW-1:0] length;
  logic [dataW-1:0] data;
  logic grant; // also pops the head.

  modport buffer
  (
    output req,
    output flitId,
    output length,
    output data,
    input  grant
  );

  modport arb
  (
    input  req,
    input  flitId,
    input  length,
    output grant
  );

  modport xbar
  (
    input req,
    input flitId,
    input length,
    input data,
    input grant
  );

endinterface

/* verilog/flitBuffer.sv */
`timescale 1ns/1ps

module flitBuffer
  import routerPkg::*;
#(
  parameter int bufDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  flitKindE pushFlitId,
  input  logic [lengthW-1:0] pushLength,
  input  logic [dataW-1:0] pushData,
  output logic full,
  flitPortIf.buffer head
);

  localparam int ptrW = $clog2(bufDepth);

  flitKindE idMem [bufDepth];
  logic [lengthW-1:0] lengthMem [bufDepth];
  logic [dataW-1:0] dataMem [bufDepth];

  logic [ptrW-1:0] rdPtr;
  logic [ptrW-1:0] wrPtr;
  logic [ptrW:0] count;
  logic [ptrW:0] nextCount;
  logic notEmpty;
  logic doPush;
  logic doPop;

  assign notEmpty = (count != '0);
  assign doPush = push && !full; // push into a full buffer is lost.
  assign doPop = head.grant && notEmpty;
  assign nextCount = count + {{ptrW{1'b0}}, doPush} - {{ptrW{1'b0}}, doPop};

  always_ff @(posedge clk)
  begin
    if (doPush)
    begin
      idMem[wrPtr] <= pushFlitId;
      lengthMem[wrPtr] <= pushLength;
      dataMem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
      full <= 1'b0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1; // wraps, depth is a power of two.
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      count <= nextCount;
      full <= (nextCount == bufDepth);
    end
  end

  // empty buffer shows an idle flit so no stale header reaches the timer
  assign head.req = notEmpty;
  assign head.flitId = notEmpty ? idMem[rdPtr] : kIdle;
  assign head.length = lengthMem[rdPtr];
  assign head.data = dataMem[rdPtr];

endmodule

/* verilog/grantTimer.sv */
`timescale 1ns/1ps

module grantTimer
  import routerPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  flitKindE flitId,
  input  logic [lengthW-1:0] length,
  input  logic hold,
  output logic timesup
);

  logic [lengthW-1:0] limit;
  logic [lengthW-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == kHead)
        limit <= length; // new packet sets the budget.
      if (hold)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesup = (count == limit);

endmodule

/* verilog/switchArbiter.sv */
`timescale 1ns/1ps

module switchArbiter
  import routerPkg::*;
(
  input  logic clk,
  input  logic rst,
  flitPortIf.arb pL,
  flitPortIf.arb pN,
  flitPortIf.arb pE,
  flitPortIf.arb pW,
  flitPortIf.arb pS
);

  arbStateE state;
  arbStateE nextState;
  portE owner;
  logic owns;
  logic stay;
  logic othersReq;
  logic [numPorts-1:0] reqV;
  logic [numPorts-1:0] timesupV;
  logic [numPorts-1:0] holdV;
  logic [numPorts:0] nextOneHot;

  assign reqV = {pS.req, pW.req, pE.req, pN.req, pL.req};

  grantTimer timerL (.clk(clk), .rst(rst), .flitId(pL.flitId), .length(pL.length),
                     .hold(holdV[0]), .timesup(timesupV[0]));
  grantTimer timerN (.clk(clk), .rst(rst), .flitId(pN.flitId), .length(pN.length),
                     .hold(holdV[1]), .timesup(timesupV[1]));
  grantTimer timerE (.clk(clk), .rst(rst), .flitId(pE.flitId), .length(pE.length),
                     .hold(holdV[2]), .timesup(timesupV[2]));
  grantTimer timerW (.clk(clk), .rst(rst), .flitId(pW.flitId), .length(pW.length),
                     .hold(holdV[3]), .timesup(timesupV[3]));
  grantTimer timerS (.clk(clk), .rst(rst), .flitId(pS.flitId), .length(pS.length),
                     .hold(holdV[4]), .timesup(timesupV[4]));

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= sIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    owns = 1'b1;
    case (state)
      sOwnL: owner = routerPkg::pL;
      sOwnN: owner = routerPkg::pN;
      sOwnE: owner = routerPkg::pE;
      sOwnW: owner = routerPkg::pW;
      sOwnS: owner = routerPkg::pS;
      default:
      begin
        owner = routerPkg::pS; // so the idle search begins at L.
        owns = 1'b0;
      end
    endcase
  end

  assign othersReq = |(reqV & ~state[numPorts:1]);

  always_comb
  begin
    int idx;
    logic found;
    holdV = '0;
    // an expired owner keeps the output only while nobody else asks
    stay = owns && reqV[owner] && (!timesupV[owner] || !othersReq);
    if (owns && reqV[owner] && !timesupV[owner])
      holdV[owner] = 1'b1;
    nextOneHot = '0;
    nextOneHot[0] = 1'b1;
    found = 1'b0;
    for (int k = 1; k <= numPorts; k++)
    begin
      idx = (int'(owner) + k) % numPorts; // owner itself comes last.
      if (!found && reqV[idx])
      begin
        found = 1'b1;
        nextOneHot = '0;
        nextOneHot[idx + 1] = 1'b1;
      end
    end
    if (stay)
      nextState = state;
    else
      nextState = arbStateE'(nextOneHot);
  end

  assign pL.grant = state[1];
  assign pN.grant = state[2];
  assign pE.grant = state[3];
  assign pW.grant = state[4];
  assign pS.grant = state[5];

endmodule

/* verilog/outputCrossbar.sv */
`timescale 1ns/1ps

module outputCrossbar
  import routerPkg::*;
(
  input  logic clk,
  input  logic rst,
  flitPortIf.xbar pL,
  flitPortIf.xbar pN,
  flitPortIf.xbar pE,
  flitPortIf.xbar pW,
  flitPortIf.xbar pS,
  output logic outValid,
  output flitKindE outFlitId,
  output logic [lengthW-1:0] outLength,
  output logic [dataW-1:0] outData
);

  logic selValid;
  flitKindE selId;
  logic [lengthW-1:0] selLength;
  logic [dataW-1:0] selData;

  always_comb
  begin
    selValid = 1'b0;
    selId = kIdle;
    selLength = '0;
    selData = '0;
    case (1'b1) // grants are one-hot.
      pL.grant:
      begin
        selValid = pL.req;
        selId = pL.flitId;
        selLength = pL.length;
        selData = pL.data;
      end
      pN.grant:
      begin
        selValid = pN.req;
        selId = pN.flitId;
        selLength = pN.length;
        selData = pN.data;
      end
      pE.grant:
      begin
        selValid = pE.req;
        selId = pE.flitId;
        selLength = pE.length;
        selData = pE.data;
      end
      pW.grant:
      begin
        selValid = pW.req;
        selId = pW.flitId;
        selLength = pW.length;
        selData = pW.data;
      end
      pS.grant:
      begin
        selValid = pS.req;
        selId = pS.flitId;
        selLength = pS.length;
        selData = pS.data;
      end
      default: selValid = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    if (selValid)
    begin
      outFlitId <= selId;
      outLength <= selLength;
      outData <= selData;
    end
  end

endmodule

/* verilog/routerOutputStage.sv */
`timescale 1ns/1ps

module routerOutputStage
  import routerPkg::*;
#(
  parameter int bufDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  logic LPush,
  input  flitKindE LFlitId,
  input  logic [lengthW-1:0] LLength,
  input  logic [dataW-1:0] LData,
  output logic LFull,
  input  logic NPush,
  input  flitKindE NFlitId,
  input  logic [lengthW-1:0] NLength,
  input  logic [dataW-1:0] NData,
  output logic NFull,
  input  logic EPush,
  input  flitKindE EFlitId,
  input  logic [lengthW-1:0] ELength,
  input  logic [dataW-1:0] EData,
  output logic EFull,
  input  logic WPush,
  input  flitKindE WFlitId,
  input  logic [lengthW-1:0] WLength,
  input  logic [dataW-1:0] WData,
  output logic WFull,
  input  logic SPush,
  input  flitKindE SFlitId,
  input  logic [lengthW-1:0] SLength,
  input  logic [dataW-1:0] SData,
  output logic SFull,
  output logic [numPorts-1:0] grant,
  output logic outValid,
  output flitKindE outFlitId,
  output logic [lengthW-1:0] outLength,
  output logic [dataW-1:0] outData
);

  flitPortIf lIf ();
  flitPortIf nIf ();
  flitPortIf eIf ();
  flitPortIf wIf ();
  flitPortIf sIf ();

  flitBuffer #(.bufDepth(bufDepth)) bufL
    (.clk(clk), .rst(rst), .push(LPush), .pushFlitId(LFlitId), .pushLength(LLength),
     .pushData(LData), .full(LFull), .head(lIf));
  flitBuffer #(.bufDepth(bufDepth)) bufN
    (.clk(clk), .rst(rst), .push(NPush), .pushFlitId(NFlitId), .pushLength(NLength),
     .pushData(NData), .full(NFull), .head(nIf));
  flitBuffer #(.bufDepth(bufDepth)) bufE
    (.clk(clk), .rst(rst), .push(EPush), .pushFlitId(EFlitId), .pushLength(ELength),
     .pushData(EData), .full(EFull), .head(eIf));
  flitBuffer #(.bufDepth(bufDepth)) bufW
    (.clk(clk), .rst(rst), .push(WPush), .pushFlitId(WFlitId), .pushLength(WLength),
     .pushData(WData), .full(WFull), .head(wIf));
  flitBuffer #(.bufDepth(bufDepth)) bufS
    (.clk(clk), .rst(rst), .push(SPush), .pushFlitId(SFlitId), .pushLength(SLength),
     .pushData(SData), .full(SFull), .head(sIf));

  switchArbiter arbiter
    (.clk(clk), .rst(rst), .pL(lIf), .pN(nIf), .pE(eIf), .pW(wIf), .pS(sIf));

  outputCrossbar xbar
    (.clk(clk), .rst(rst), .pL(lIf), .pN(nIf), .pE(eIf), .pW(wIf), .pS(sIf),
     .outValid(outValid), .outFlitId(outFlitId), .outLength(outLength),
     .outData(outData));

  assign grant = {sIf.grant, wIf.grant, eIf.grant, nIf.grant, lIf.grant}; // bit 0 is L.

endmodule

/* verification/switchArbiter_asserts.sv */
`timescale 1ns/1ps

module switchArbiter_asserts
  import routerPkg::*;
(
  input logic clk,
  input logic rst,
  input logic [numPorts-1:0] reqV,
  input logic [numPorts-1:0] timesupV,
  input logic [numPorts-1:0] grantV
);

  int failCount = 0; // read by the testbench at the end.

  task automatic noteFailure(string what);
    $error("%s", what);
    failCount++;
  endtask

  // first requester after the old owner, the old owner last, zero if none
  function automatic logic [numPorts-1:0] rotateNext(logic [numPorts-1:0] oldGrant,
                                                     logic [numPorts-1:0] reqs);
    int start;
    int idx;
    logic [numPorts-1:0] pick;
    start = numPorts - 1; // from idle the search begins at L.
    pick = '0;
    for (int p = 0; p < numPorts; p++)
      if (oldGrant[p])
        start = p;
    for (int k = numPorts; k >= 1; k--)
    begin
      idx = (start + k) % numPorts;
      if (reqs[idx])
        pick = numPorts'(1) << idx; // nearest one wins, it is written last.
    end
    return pick;
  endfunction

  resetIdle: assert property (@(posedge clk) rst |=> grantV == '0)
    else noteFailure("grant is not zero after reset");

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grantV))
    else noteFailure("grant is neither zero nor one-hot");

  grantNeedsReq: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (grantV & ~$past(reqV)) == '0)
    else noteFailure("a port was granted without a request");

  rotation: assert property (@(posedge clk) disable iff (rst)
    grantV != $past(grantV) |-> grantV == rotateNext($past(grantV), $past(reqV)))
    else noteFailure("new owner does not follow the rotation order");

  timerRelease: assert property (@(posedge clk) disable iff (rst)
    (|(grantV & reqV & timesupV)) && (|(reqV & ~grantV)) |=> grantV != $past(grantV))
    else noteFailure("owner kept the output past its grant limit");

  idleReturn: assert property (@(posedge clk) disable iff (rst)
    reqV == '0 |=> grantV == '0)
    else noteFailure("grant did not return to zero with no requests");

endmodule

bind switchArbiter switchArbiter_asserts asserts
  (.clk(clk), .rst(rst), .reqV(reqV), .timesupV(timesupV), .grantV(state[5:1]));

/* verification/routerTb.sv */
`timescale 1ns/1ps

module routerTb
  import routerPkg::*;
();

  localparam int numPackets = 60;
  localparam int bufDepth = 4;

  logic clk = 1'b0;
  logic rst;
  logic push [numPorts];
  flitKindE fid [numPorts];
  logic [lengthW-1:0] len [numPorts];
  logic [dataW-1:0] dat [numPorts];
  logic full [numPorts];
  logic [numPorts-1:0] grant;
  logic outValid;
  flitKindE outFlitId;
  logic [lengthW-1:0] outLength;
  logic [dataW-1:0] outData;

  logic [numPorts-1:0] prevGrant;
  logic [30:0] refQ [numPorts][$]; // id, length, data of each pushed flit.
  int pktLen [numPorts];
  int left [numPorts];
  int errCount;

  routerOutputStage #(.bufDepth(bufDepth)) i_dut
  (
    .clk(clk), .rst(rst),
    .LPush(push[0]), .LFlitId(fid[0]), .LLength(len[0]), .LData(dat[0]), .LFull(full[0]),
    .NPush(push[1]), .NFlitId(fid[1]), .NLength(len[1]), .NData(dat[1]), .NFull(full[1]),
    .EPush(push[2]), .EFlitId(fid[2]), .ELength(len[2]), .EData(dat[2]), .EFull(full[2]),
    .WPush(push[3]), .WFlitId(fid[3]), .WLength(len[3]), .WData(dat[3]), .WFull(full[3]),
    .SPush(push[4]), .SFlitId(fid[4]), .SLength(len[4]), .SData(dat[4]), .SFull(full[4]),
    .grant(grant), .outValid(outValid), .outFlitId(outFlitId), .outLength(outLength),
    .outData(outData)
  );

  always #2 clk = ~clk;

  task automatic compareField(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
      errCount++;
    end
  endtask

  // next flit of the packet in progress on direction d
  task automatic sendFlit(int d);
    if (left[d] == pktLen[d] + 1)
    begin
      fid[d] = kHead;
      len[d] = lengthW'(pktLen[d]);
    end
    else
    begin
      fid[d] = (left[d] == 1) ? kTail : kBody;
      len[d] = '0;
    end
    dat[d] = dataW'($urandom);
    push[d] = 1'b1;
    refQ[d].push_back({fid[d], len[d], dat[d]});
    left[d]--;
  endtask

  task automatic checkOutput();
    int d;
    logic [30:0] expFlit;
    d = -1;
    for (int p = 0; p < numPorts; p++)
      if (prevGrant[p])
        d = p;
    if (d < 0)
    begin
      $display("outValid was high at %0t without a grant in the cycle before", $time);
      errCount++;
    end
    else if (refQ[d].size() == 0)
    begin
      $display("port %0d sent a flit at %0t that was never pushed", d, $time);
      errCount++;
    end
    else
    begin
      expFlit = refQ[d].pop_front();
      compareField("outFlitId", 32'(expFlit[30:28]), 32'(outFlitId));
      compareField("outLength", 32'(expFlit[27:16]), 32'(outLength));
      compareField("outData", 32'(expFlit[15:0]), 32'(outData));
    end
  endtask

  // a buffer holds what was written before this cycle and not yet sent
  task automatic verifyFullFlags();
    int held;
    for (int d = 0; d < numPorts; d++)
    begin
      held = refQ[d].size() - (push[d] ? 1 : 0);
      compareField($sformatf("full[%0d]", d), 32'(held == bufDepth), 32'(full[d]));
    end
  endtask

  function automatic bit drained();
    for (int p = 0; p < numPorts; p++)
      if (refQ[p].size() != 0 || left[p] != 0)
        return 1'b0;
    return 1'b1;
  endfunction

  // outputs are settled at the falling edge
  always @(negedge clk)
  begin
    if (rst)
      prevGrant = '0;
    else
    begin
      if (outValid)
        checkOutput();
      verifyFullFlags();
      prevGrant = grant;
    end
  end

  initial
  begin
    int started;
    int cyc;
    void'($urandom(32'h333b_ccc5));
    errCount = 0;
    for (int d = 0; d < numPorts; d++)
    begin
      push[d] = 1'b0;
      fid[d] = kIdle;
      len[d] = '0;
      dat[d] = '0;
      left[d] = 0;
      pktLen[d] = 0;
    end
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #0.5 rst = 1'b0;
    repeat (3) @(negedge clk);
    compareField("grant", 32'h0, 32'(grant)); // nothing pushed yet.
    compareField("outValid", 32'h0, 32'(outValid));

    started = 0;
    cyc = 0;
    while ((started < numPackets || !drained()) && cyc < 5000)
    begin
      @(posedge clk);
      #0.5;
      for (int d = 0; d < numPorts; d++)
      begin
        push[d] = 1'b0;
        if (left[d] == 0 && started < numPackets && $urandom_range(2) == 0)
        begin
          pktLen[d] = int'($urandom_range(8, 1));
          left[d] = pktLen[d] + 1;
          started++;
        end
        if (left[d] != 0 && !full[d] && $urandom_range(1) == 1)
          sendFlit(d);
      end
      cyc++;
    end
    @(posedge clk);
    #0.5;
    for (int d = 0; d < numPorts; d++)
      push[d] = 1'b0;
    if (cyc >= 5000)
    begin
      $display("timeout: stimulus or output drain did not finish in 5000 cycles");
      errCount++;
    end
    repeat (4) @(posedge clk); // idle return seen by the assertions.

    $display("errors: scoreboard %0d, assertions %0d", errCount,
             i_dut.arbiter.asserts.failCount);
    if (errCount == 0 && i_dut.arbiter.asserts.failCount == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* build.f */
verilog/routerPkg.sv
verilog/flitPortIf.sv
verilog/flitBuffer.sv
verilog/grantTimer.sv
verilog/switchArbiter.sv
verilog/outputCrossbar.sv
verilog/routerOutputStage.sv
verification/switchArbiter_asserts.sv
verification/routerTb.sv

/* run.sh */
#!/bin/sh
# compile and run the router output stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module routerTb -f build.f -o routerSim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/routerSim +verilator+error+limit+1000 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
